// ==== bypass_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module bypass_unit (
    input  wire lc4_pipe_pkg::ctrl_t i_x_ctrl,
    input  wire lc4_pipe_pkg::ctrl_t i_m_ctrl,
    input  wire lc4_pipe_pkg::ctrl_t i_w_ctrl,
    input  wire lc4_isa_pkg::word_t  i_x_rs_data,
    input  wire lc4_isa_pkg::word_t  i_x_rt_data,
    input  wire lc4_isa_pkg::word_t  i_m_result,
    input  wire lc4_isa_pkg::word_t  i_w_data,
    input  wire lc4_isa_pkg::word_t  i_m_store_data,
    output lc4_isa_pkg::word_t       o_rs,
    output lc4_isa_pkg::word_t       o_rt,
    output lc4_isa_pkg::word_t       o_store_data
);

    logic rs_mx;
    logic rs_wx;
    logic rt_mx;
    logic rt_wx;
    logic st_wm;

    // MX paths, the younger producer wins
    assign rs_mx = i_x_ctrl.rs_re && i_m_ctrl.rd_we && (i_m_ctrl.rd == i_x_ctrl.rs);
    assign rt_mx = i_x_ctrl.rt_re && i_m_ctrl.rd_we && (i_m_ctrl.rd == i_x_ctrl.rt);

    // WX paths
    assign rs_wx = i_x_ctrl.rs_re && i_w_ctrl.rd_we && (i_w_ctrl.rd == i_x_ctrl.rs);
    assign rt_wx = i_x_ctrl.rt_re && i_w_ctrl.rd_we && (i_w_ctrl.rd == i_x_ctrl.rt);

    assign o_rs = rs_mx ? i_m_result :
                  rs_wx ? i_w_data   :
                          i_x_rs_data;
    assign o_rt = rt_mx ? i_m_result :
                  rt_wx ? i_w_data   :
                          i_x_rt_data;

    // covers a load directly ahead of the store that supplies its data
    assign st_wm = i_m_ctrl.is_store && i_w_ctrl.rd_we && (i_w_ctrl.rd == i_m_ctrl.rt);

    assign o_store_data = st_wm ? i_w_data : i_m_store_data;

endmodule

`default_nettype wire

// ==== files.f ====
lc4_isa_pkg.sv
lc4_pipe_pkg.sv
insn_decoder.sv
lc4_alu.sv
lc4_regfile.sv
hazard_unit.sv
bypass_unit.sv
lc4_pipeline.sv
tb_clock_gen.sv
tb_lc4_pipeline.sv

// ==== hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  wire lc4_pipe_pkg::ctrl_t i_d_ctrl,
    input  wire lc4_pipe_pkg::ctrl_t i_x_ctrl,
    input  wire lc4_isa_pkg::word_t  i_x_insn,
    input  wire lc4_pipe_pkg::ctrl_t i_m_ctrl,
    input  wire lc4_isa_pkg::nzp_t   i_m_nzp,
    input  wire lc4_isa_pkg::nzp_t   i_nzp_reg,
    output logic                     o_stall,
    output logic                     o_branch_taken,
    output lc4_pipe_pkg::stall_code_t o_stall_code
);

    logic              load_use;
    logic              load_branch;
    lc4_isa_pkg::nzp_t cur_nzp;

    // store data reaches M in time through the WM path
    assign load_use = i_x_ctrl.is_load &&
                      ((i_d_ctrl.rs_re && i_d_ctrl.rs == i_x_ctrl.rd) ||
                       (i_d_ctrl.rt_re && !i_d_ctrl.is_store && i_d_ctrl.rt == i_x_ctrl.rd));

    // the load nzp is only known once the load leaves M
    assign load_branch = i_d_ctrl.is_branch && i_x_ctrl.is_load;
    assign o_stall     = load_use || load_branch;

    // the instruction in M sets the condition one edge from now
    assign cur_nzp = i_m_ctrl.rd_we ? i_m_nzp : i_nzp_reg;

    assign o_branch_taken = i_x_ctrl.is_branch &&
                            |(i_x_insn[lc4_isa_pkg::NZP_LSB +: 3] & cur_nzp);

    assign o_stall_code = o_branch_taken ? lc4_pipe_pkg::STALL_FLUSH :
                          o_stall        ? lc4_pipe_pkg::STALL_LOAD  :
                                           lc4_pipe_pkg::STALL_NONE;

endmodule

`default_nettype wire

// ==== insn_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module insn_decoder (
    input  wire lc4_isa_pkg::word_t i_insn,
    output lc4_pipe_pkg::ctrl_t     o_ctrl,
    output lc4_isa_pkg::word_t      o_imm
);

    logic [3:0] opcode;
    logic [2:0] sub_op;
    logic       imm_form;

    assign opcode   = i_insn[lc4_isa_pkg::OPC_LSB +: 4];
    assign sub_op   = i_insn[lc4_isa_pkg::SUB_LSB +: 3];
    assign imm_form = i_insn[lc4_isa_pkg::IMM_FLAG_BIT];

    always_comb begin
        o_ctrl    = '0;
        o_imm     = '0;
        o_ctrl.rd = i_insn[lc4_isa_pkg::RD_LSB +: 3];
        o_ctrl.rs = i_insn[lc4_isa_pkg::RS_LSB +: 3];
        o_ctrl.rt = i_insn[lc4_isa_pkg::RT_LSB +: 3];
        case (opcode)
            lc4_isa_pkg::OPC_BR: begin
                o_imm = 16'($signed(i_insn[lc4_isa_pkg::IMM9_W-1:0]));
                // nzp 000 never branches and decodes as a NOP
                o_ctrl.is_branch = |i_insn[lc4_isa_pkg::NZP_LSB +: 3];
            end
            lc4_isa_pkg::OPC_ARITH, lc4_isa_pkg::OPC_LOGIC: begin
                o_imm = 16'($signed(i_insn[lc4_isa_pkg::IMM5_W-1:0]));
                if (imm_form) begin
                    o_ctrl.rs_re = 1'b1;
                    o_ctrl.rd_we = 1'b1;
                end else if ((opcode == lc4_isa_pkg::OPC_ARITH &&
                              (sub_op == lc4_isa_pkg::SUB_ADD ||
                               sub_op == lc4_isa_pkg::SUB_SUB)) ||
                             (opcode == lc4_isa_pkg::OPC_LOGIC &&
                              (sub_op == lc4_isa_pkg::SUB_AND ||
                               sub_op == lc4_isa_pkg::SUB_OR ||
                               sub_op == lc4_isa_pkg::SUB_XOR))) begin
                    o_ctrl.rs_re = 1'b1;
                    o_ctrl.rt_re = 1'b1;
                    o_ctrl.rd_we = 1'b1;
                end
            end
            lc4_isa_pkg::OPC_LDR: begin
                o_imm          = 16'($signed(i_insn[lc4_isa_pkg::IMM6_W-1:0]));
                o_ctrl.rs_re   = 1'b1;
                o_ctrl.rd_we   = 1'b1;
                o_ctrl.is_load = 1'b1;
            end
            lc4_isa_pkg::OPC_STR: begin
                o_imm           = 16'($signed(i_insn[lc4_isa_pkg::IMM6_W-1:0]));
                // the stored register sits in the rd field
                o_ctrl.rt       = i_insn[lc4_isa_pkg::RD_LSB +: 3];
                o_ctrl.rs_re    = 1'b1;
                o_ctrl.rt_re    = 1'b1;
                o_ctrl.is_store = 1'b1;
            end
            lc4_isa_pkg::OPC_CONST: begin
                o_imm        = 16'($signed(i_insn[lc4_isa_pkg::IMM9_W-1:0]));
                o_ctrl.rd_we = 1'b1;
            end
            default: begin
                o_imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== lc4_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_alu (
    input  wire lc4_isa_pkg::word_t i_insn,
    input  wire lc4_isa_pkg::word_t i_pc,
    input  wire lc4_isa_pkg::word_t i_rs,
    input  wire lc4_isa_pkg::word_t i_rt,
    input  wire lc4_isa_pkg::word_t i_imm,
    output lc4_isa_pkg::word_t      o_result
);

    logic [2:0] sub_op;
    logic       imm_form;

    assign sub_op   = i_insn[lc4_isa_pkg::SUB_LSB +: 3];
    assign imm_form = i_insn[lc4_isa_pkg::IMM_FLAG_BIT];

    always_comb begin
        case (i_insn[lc4_isa_pkg::OPC_LSB +: 4])
            // branch target relative to the next instruction
            lc4_isa_pkg::OPC_BR: o_result = i_pc + 16'd1 + i_imm;
            lc4_isa_pkg::OPC_ARITH: begin
                if (imm_form) begin
                    o_result = i_rs + i_imm;
                end else begin
                    case (sub_op)
                        lc4_isa_pkg::SUB_ADD: o_result = i_rs + i_rt;
                        lc4_isa_pkg::SUB_SUB: o_result = i_rs - i_rt;
                        default:              o_result = '0;
                    endcase
                end
            end
            lc4_isa_pkg::OPC_LOGIC: begin
                if (imm_form) begin
                    o_result = i_rs & i_imm;
                end else begin
                    case (sub_op)
                        lc4_isa_pkg::SUB_AND: o_result = i_rs & i_rt;
                        lc4_isa_pkg::SUB_OR:  o_result = i_rs | i_rt;
                        lc4_isa_pkg::SUB_XOR: o_result = i_rs ^ i_rt;
                        default:              o_result = '0;
                    endcase
                end
            end
            // effective address for memory access
            lc4_isa_pkg::OPC_LDR, lc4_isa_pkg::OPC_STR: o_result = i_rs + i_imm;
            lc4_isa_pkg::OPC_CONST: o_result = i_imm;
            default: o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== lc4_isa_pkg.sv ====
`default_nettype none

package lc4_isa_pkg;

    // one machine word serves as instruction, data and address
    typedef logic [15:0] word_t;
    typedef logic [2:0] reg_idx_t;

    // bit 2 negative, bit 1 zero, bit 0 positive
    typedef logic [2:0] nzp_t;

    // major opcodes of the supported subset, insn[15:12]
    localparam logic [3:0] OPC_BR    = 4'b0000;
    localparam logic [3:0] OPC_ARITH = 4'b0001;
    localparam logic [3:0] OPC_LOGIC = 4'b0101;
    localparam logic [3:0] OPC_LDR   = 4'b0110;
    localparam logic [3:0] OPC_STR   = 4'b0111;
    localparam logic [3:0] OPC_CONST = 4'b1001;

    // sub-opcodes in insn[5:3] of the register forms
    localparam logic [2:0] SUB_ADD = 3'b000;
    localparam logic [2:0] SUB_SUB = 3'b010;
    localparam logic [2:0] SUB_AND = 3'b000;
    localparam logic [2:0] SUB_OR  = 3'b010;
    localparam logic [2:0] SUB_XOR = 3'b011;

    // field positions, all three-bit selects given by their low bit
    localparam int OPC_LSB = 12;
    localparam int RD_LSB  = 9;
    localparam int NZP_LSB = 9;
    localparam int RS_LSB  = 6;
    localparam int SUB_LSB = 3;
    localparam int RT_LSB  = 0;
    // set in arith and logic when the second operand is imm5
    localparam int IMM_FLAG_BIT = 5;

    // immediates all start at bit 0
    localparam int IMM5_W = 5;
    localparam int IMM6_W = 6;
    localparam int IMM9_W = 9;

endpackage

`default_nettype wire

// ==== lc4_patterns.hex ====
// 0x00 program words, 0x40 data memory words 0..15, 0x50 record count
// 0x51 records: kind pc sel value; kind 1 write (sel = rd), 2 bubble (value = code), 3 store (sel = addr)
@00
9205 95FD 1642 18D1 5B1A 5C54 5F81 1B67
5DBE 9008 6200 1441 7401 6601 0202 9E01
9E02 0801 0000 18FF 7802 6A02 9E1F 0FFF
@40
1000 1001 1002 1003 1004 1005 1006 1007
0021 1009 100A 100B 100C 100D 100E 100F
@50
0016
// dependent ALU chain
0001 0000 0001 0005
0001 0001 0002 FFFD
0001 0002 0003 0002
0001 0003 0004 FFFD
0001 0004 0005 0000
0001 0005 0006 FFFD
0001 0006 0007 0005
0001 0007 0005 0007
0001 0008 0006 FFFC
0001 0009 0000 0008
// load then use, with a load bubble between
0001 000A 0001 0021
0002 0000 0000 0003
0001 000B 0002 0042
0003 000C 0009 0042
0001 000D 0003 0042
// branch after load stalls, then a taken branch flushes two
0002 0000 0000 0003
0002 0000 0000 0002
0002 0000 0000 0002
0001 0013 0004 0041
0003 0014 000A 0041
0001 0015 0005 0041
0001 0016 0007 001F

// ==== lc4_pipe_pkg.sv ====
`default_nettype none

package lc4_pipe_pkg;

    // reason a stage holds a bubble, as seen on the writeback trace
    typedef enum logic [1:0] {
        STALL_NONE  = 2'd0,
        STALL_FLUSH = 2'd2,
        STALL_LOAD  = 2'd3
    } stall_code_t;

    // decoded control of one instruction, all zero for a bubble
    typedef struct packed {
        lc4_isa_pkg::reg_idx_t rs;
        lc4_isa_pkg::reg_idx_t rt;
        lc4_isa_pkg::reg_idx_t rd;
        logic                  rs_re;
        logic                  rt_re;
        logic                  rd_we;
        logic                  is_load;
        logic                  is_store;
        logic                  is_branch;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== lc4_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_pipeline #(
    parameter lc4_isa_pkg::word_t RESET_PC = 16'h0000
) (
    input  wire                        gwe,
    input  wire                        i_rst_n,
    output lc4_isa_pkg::word_t         o_imem_addr,
    input  wire lc4_isa_pkg::word_t    i_imem_insn,
    output lc4_isa_pkg::word_t         o_dmem_addr,
    output logic                       o_dmem_we,
    output lc4_isa_pkg::word_t         o_dmem_wdata,
    input  wire lc4_isa_pkg::word_t    i_dmem_rdata,
    output lc4_isa_pkg::word_t         o_wb_pc,
    output lc4_isa_pkg::word_t         o_wb_insn,
    output logic                       o_wb_we,
    output lc4_isa_pkg::reg_idx_t      o_wb_wsel,
    output lc4_isa_pkg::word_t         o_wb_data,
    output lc4_pipe_pkg::stall_code_t  o_wb_stall
);

    lc4_isa_pkg::word_t        pc;
    lc4_isa_pkg::word_t        pc_next;

    lc4_isa_pkg::word_t        d_pc, d_insn, d_imm, rf_rs_data, rf_rt_data;
    lc4_pipe_pkg::ctrl_t       d_ctrl;
    lc4_pipe_pkg::stall_code_t d_stall;

    lc4_isa_pkg::word_t        x_pc, x_insn, x_imm, x_rs_data, x_rt_data;
    lc4_isa_pkg::word_t        bp_rs, bp_rt, alu_result;
    lc4_pipe_pkg::ctrl_t       x_ctrl;
    lc4_pipe_pkg::stall_code_t x_stall;

    lc4_isa_pkg::word_t        m_pc, m_insn, m_result, m_store_data, bp_store_data, m_value;
    lc4_pipe_pkg::ctrl_t       m_ctrl;
    lc4_pipe_pkg::stall_code_t m_stall;
    lc4_isa_pkg::nzp_t         m_nzp, nzp_reg;

    lc4_isa_pkg::word_t        w_pc, w_insn, w_result, w_load_data, w_data;
    lc4_pipe_pkg::ctrl_t       w_ctrl;
    lc4_pipe_pkg::stall_code_t w_stall;

    logic                      hz_stall;
    logic                      hz_taken;
    lc4_pipe_pkg::stall_code_t hz_code;

    // fetch
    assign pc_next     = hz_taken ? alu_result : (hz_stall ? pc : pc + 16'd1);
    assign o_imem_addr = pc;

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // decode, held on a stall and emptied by a taken branch
    always_ff @(posedge gwe) begin
        if (!i_rst_n || hz_taken) begin
            d_pc    <= '0;
            d_insn  <= '0;
            d_stall <= lc4_pipe_pkg::STALL_FLUSH;
        end else if (!hz_stall) begin
            d_pc    <= pc;
            d_insn  <= i_imem_insn;
            d_stall <= lc4_pipe_pkg::STALL_NONE;
        end
    end

    insn_decoder u_decoder (
        .i_insn (d_insn),
        .o_ctrl (d_ctrl),
        .o_imm  (d_imm)
    );

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_rst_n   (i_rst_n),
        .i_rs      (d_ctrl.rs),
        .i_rt      (d_ctrl.rt),
        .o_rs_data (rf_rs_data),
        .o_rt_data (rf_rt_data),
        .i_rd      (w_ctrl.rd),
        .i_wdata   (w_data),
        .i_we      (w_ctrl.rd_we)
    );

    hazard_unit u_hazard (
        .i_d_ctrl       (d_ctrl),
        .i_x_ctrl       (x_ctrl),
        .i_x_insn       (x_insn),
        .i_m_ctrl       (m_ctrl),
        .i_m_nzp        (m_nzp),
        .i_nzp_reg      (nzp_reg),
        .o_stall        (hz_stall),
        .o_branch_taken (hz_taken),
        .o_stall_code   (hz_code)
    );

    // execute, a bubble enters on a stall or a taken branch
    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            x_pc    <= '0;
            x_insn  <= '0;
            x_ctrl  <= '0;
            x_stall <= lc4_pipe_pkg::STALL_FLUSH;
        end else if (hz_code != lc4_pipe_pkg::STALL_NONE) begin
            x_pc    <= '0;
            x_insn  <= '0;
            x_ctrl  <= '0;
            x_stall <= hz_code;
        end else begin
            x_pc    <= d_pc;
            x_insn  <= d_insn;
            x_ctrl  <= d_ctrl;
            x_stall <= d_stall;
        end
    end

    always_ff @(posedge gwe) begin
        x_imm     <= d_imm;
        x_rs_data <= rf_rs_data;
        x_rt_data <= rf_rt_data;
    end

    bypass_unit u_bypass (
        .i_x_ctrl       (x_ctrl),
        .i_m_ctrl       (m_ctrl),
        .i_w_ctrl       (w_ctrl),
        .i_x_rs_data    (x_rs_data),
        .i_x_rt_data    (x_rt_data),
        .i_m_result     (m_result),
        .i_w_data       (w_data),
        .i_m_store_data (m_store_data),
        .o_rs           (bp_rs),
        .o_rt           (bp_rt),
        .o_store_data   (bp_store_data)
    );

    lc4_alu u_alu (
        .i_insn   (x_insn),
        .i_pc     (x_pc),
        .i_rs     (bp_rs),
        .i_rt     (bp_rt),
        .i_imm    (x_imm),
        .o_result (alu_result)
    );

    // memory
    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            m_pc    <= '0;
            m_insn  <= '0;
            m_ctrl  <= '0;
            m_stall <= lc4_pipe_pkg::STALL_FLUSH;
        end else begin
            m_pc    <= x_pc;
            m_insn  <= x_insn;
            m_ctrl  <= x_ctrl;
            m_stall <= x_stall;
        end
    end

    always_ff @(posedge gwe) begin
        m_result     <= alu_result;
        m_store_data <= bp_rt;
    end

    assign o_dmem_addr  = (m_ctrl.is_load || m_ctrl.is_store) ? m_result : '0;
    assign o_dmem_we    = m_ctrl.is_store;
    assign o_dmem_wdata = m_ctrl.is_store ? bp_store_data : '0;

    // condition code of the value this instruction will write
    assign m_value = m_ctrl.is_load ? i_dmem_rdata : m_result;
    assign m_nzp   = m_value[15]     ? 3'b100 :
                     (m_value == '0) ? 3'b010 :
                                       3'b001;

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            nzp_reg <= '0;
        end else if (m_ctrl.rd_we) begin
            nzp_reg <= m_nzp;
        end
    end

    // writeback
    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            w_pc    <= '0;
            w_insn  <= '0;
            w_ctrl  <= '0;
            w_stall <= lc4_pipe_pkg::STALL_FLUSH;
        end else begin
            w_pc    <= m_pc;
            w_insn  <= m_insn;
            w_ctrl  <= m_ctrl;
            w_stall <= m_stall;
        end
    end

    always_ff @(posedge gwe) begin
        w_result    <= m_result;
        w_load_data <= i_dmem_rdata;
    end

    assign w_data = w_ctrl.is_load ? w_load_data : w_result;

    assign o_wb_pc    = w_pc;
    assign o_wb_insn  = w_insn;
    assign o_wb_we    = w_ctrl.rd_we;
    assign o_wb_wsel  = w_ctrl.rd;
    assign o_wb_data  = w_data;
    assign o_wb_stall = w_stall;

endmodule

`default_nettype wire

// ==== lc4_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_regfile (
    input  wire                        gwe,
    input  wire                        i_rst_n,
    input  wire lc4_isa_pkg::reg_idx_t i_rs,
    input  wire lc4_isa_pkg::reg_idx_t i_rt,
    output lc4_isa_pkg::word_t         o_rs_data,
    output lc4_isa_pkg::word_t         o_rt_data,
    input  wire lc4_isa_pkg::reg_idx_t i_rd,
    input  wire lc4_isa_pkg::word_t    i_wdata,
    input  wire                        i_we
);

    lc4_isa_pkg::word_t regs [8];

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // a write in W is visible to the read in D of the same cycle
    assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
    assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_lc4_pipeline -f files.f -o sim_lc4

./obj_dir/sim_lc4 > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Test OK" sim.log; then
    exit 1
fi
exit 0

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic o_clk,
    output logic o_rst_n
);

    int   rst_count = 0;
    logic rst_done  = 1'b0;

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // reset stays low for the first RESET_CYCLES rising edges
    always @(posedge o_clk) begin
        if (rst_count < RESET_CYCLES - 1) begin
            rst_count <= rst_count + 1;
        end else begin
            rst_done <= 1'b1;
        end
    end

    assign o_rst_n = rst_done;

endmodule

`default_nettype wire

// ==== tb_lc4_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lc4_pipeline;

    localparam lc4_isa_pkg::word_t RESET_PC = 16'h0000;

    // layout of the pattern image
    localparam int PROG_BASE  = 'h00;
    localparam int PROG_WORDS = 64;
    localparam int DATA_BASE  = 'h40;
    localparam int DATA_WORDS = 16;
    localparam int COUNT_ADDR = 'h50;
    localparam int REC_BASE   = 'h51;

    // record kinds in the first column of a record
    localparam int KIND_WRITE  = 1;
    localparam int KIND_BUBBLE = 2;
    localparam int KIND_STORE  = 3;

    logic                      clk;
    logic                      rst_n;
    lc4_isa_pkg::word_t        imem_addr;
    lc4_isa_pkg::word_t        imem_insn;
    lc4_isa_pkg::word_t        dmem_addr;
    logic                      dmem_we;
    lc4_isa_pkg::word_t        dmem_wdata;
    lc4_isa_pkg::word_t        dmem_rdata;
    lc4_isa_pkg::word_t        wb_pc;
    lc4_isa_pkg::word_t        wb_insn;
    logic                      wb_we;
    lc4_isa_pkg::reg_idx_t     wb_wsel;
    lc4_isa_pkg::word_t        wb_data;
    lc4_pipe_pkg::stall_code_t wb_stall;

    lc4_isa_pkg::word_t patterns [256];
    lc4_isa_pkg::word_t imem [PROG_WORDS];
    lc4_isa_pkg::word_t dmem [DATA_WORDS];

    // expected trace events in W order and expected stores in M order
    lc4_isa_pkg::word_t w_kind [$];
    lc4_isa_pkg::word_t w_pc [$];
    lc4_isa_pkg::word_t w_sel [$];
    lc4_isa_pkg::word_t w_val [$];
    lc4_isa_pkg::word_t st_pc [$];
    lc4_isa_pkg::word_t st_addr [$];
    lc4_isa_pkg::word_t st_data [$];

    int                 rec_count;
    int                 cycle_limit;
    int                 cycles = 0;
    int                 w_idx = 0;
    int                 st_idx = 0;
    logic               clk_started = 1'b0;
    logic               committed = 1'b0;
    logic               store_pending = 1'b0;
    lc4_isa_pkg::word_t store_pc;

    tb_clock_gen #(
        .PERIOD_NS    (4),
        .RESET_CYCLES (8)
    ) u_clock_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    lc4_pipeline #(
        .RESET_PC (RESET_PC)
    ) dut (
        .gwe          (clk),
        .i_rst_n      (rst_n),
        .o_imem_addr  (imem_addr),
        .i_imem_insn  (imem_insn),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_we    (dmem_we),
        .o_dmem_wdata (dmem_wdata),
        .i_dmem_rdata (dmem_rdata),
        .o_wb_pc      (wb_pc),
        .o_wb_insn    (wb_insn),
        .o_wb_we      (wb_we),
        .o_wb_wsel    (wb_wsel),
        .o_wb_data    (wb_data),
        .o_wb_stall   (wb_stall)
    );

    initial begin
        for (int i = 0; i < 256; i++) begin
            patterns[i] = '0;
        end
        $readmemh("lc4_patterns.hex", patterns);
        for (int i = 0; i < PROG_WORDS; i++) begin
            imem[i] = patterns[PROG_BASE + i];
        end
        for (int i = 0; i < DATA_WORDS; i++) begin
            dmem[i] = patterns[DATA_BASE + i];
        end
        rec_count = int'(patterns[COUNT_ADDR]);
        for (int r = 0; r < rec_count; r++) begin
            if (int'(patterns[REC_BASE + 4 * r]) == KIND_STORE) begin
                st_pc.push_back(patterns[REC_BASE + 4 * r + 1]);
                st_addr.push_back(patterns[REC_BASE + 4 * r + 2]);
                st_data.push_back(patterns[REC_BASE + 4 * r + 3]);
            end else begin
                w_kind.push_back(patterns[REC_BASE + 4 * r]);
                w_pc.push_back(patterns[REC_BASE + 4 * r + 1]);
                w_sel.push_back(patterns[REC_BASE + 4 * r + 2]);
                w_val.push_back(patterns[REC_BASE + 4 * r + 3]);
            end
        end
        cycle_limit = 8 * rec_count + 50;
        if (rec_count == 0) begin
            $display("pattern file holds no expected records");
            stop_failed();
        end
    end

    // memories answer in the same cycle
    // addresses past the image read as zero
    assign imem_insn  = (imem_addr < 16'(PROG_WORDS)) ? imem[imem_addr[5:0]] : '0;
    assign dmem_rdata = dmem[dmem_addr[3:0]];

    always @(posedge clk) begin
        clk_started <= 1'b1;
        if (dmem_we) begin
            dmem[dmem_addr[3:0]] <= dmem_wdata;
        end
    end

    task automatic stop_failed();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input lc4_isa_pkg::word_t actual,
                              input lc4_isa_pkg::word_t expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
            stop_failed();
        end
    endtask

    task automatic check_reg(input string name, input lc4_isa_pkg::reg_idx_t actual,
                             input lc4_isa_pkg::reg_idx_t expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            stop_failed();
        end
    endtask

    task automatic check_stall(input string name, input lc4_pipe_pkg::stall_code_t actual,
                               input lc4_pipe_pkg::stall_code_t expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            stop_failed();
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %b, expected %b", $time, name, actual, expected);
            stop_failed();
        end
    endtask

    // compare one trace event in W against the next expected record
    task automatic match_trace_event();
        if (w_idx >= w_kind.size()) begin
            $display("trace shows an event at %0t after all records were matched", $time);
            stop_failed();
        end
        if (int'(w_kind[w_idx]) == KIND_BUBBLE) begin
            check_stall("o_wb_stall", wb_stall, lc4_pipe_pkg::stall_code_t'(w_val[w_idx][1:0]));
            check_bit("o_wb_we", wb_we, 1'b0);
        end else if (int'(w_kind[w_idx]) == KIND_WRITE) begin
            check_stall("o_wb_stall", wb_stall, lc4_pipe_pkg::STALL_NONE);
            check_bit("o_wb_we", wb_we, 1'b1);
            check_word("o_wb_pc", wb_pc, w_pc[w_idx]);
            check_word("o_wb_insn", wb_insn, imem[w_pc[w_idx][5:0]]);
            check_reg("o_wb_wsel", wb_wsel, w_sel[w_idx][2:0]);
            check_word("o_wb_data", wb_data, w_val[w_idx]);
        end else begin
            $display("expected record %0d has an unknown kind %h", w_idx, w_kind[w_idx]);
            stop_failed();
        end
        w_idx++;
    endtask

    task automatic match_store();
        if (st_idx >= st_addr.size()) begin
            $display("unexpected store at %0t to address %h", $time, dmem_addr);
            stop_failed();
        end
        check_word("o_dmem_addr", dmem_addr, st_addr[st_idx]);
        check_word("o_dmem_wdata", dmem_wdata, st_data[st_idx]);
        store_pc      = st_pc[st_idx];
        store_pending = 1'b1;
        st_idx++;
    endtask

    // outputs are sampled on the falling edge away from the driving edge
    always @(negedge clk) begin
        if (!rst_n) begin
            if (clk_started) begin
                check_word("o_imem_addr", imem_addr, RESET_PC);
                check_bit("o_wb_we", wb_we, 1'b0);
                check_bit("o_dmem_we", dmem_we, 1'b0);
                check_stall("o_wb_stall", wb_stall, lc4_pipe_pkg::STALL_FLUSH);
            end
        end else begin
            cycles++;
            if (cycles == 1) begin
                check_word("o_imem_addr", imem_addr, RESET_PC);
            end
            // the store itself reaches W one cycle after its memory write
            if (store_pending) begin
                check_stall("o_wb_stall", wb_stall, lc4_pipe_pkg::STALL_NONE);
                check_word("o_wb_pc", wb_pc, store_pc);
                check_word("o_wb_insn", wb_insn, imem[store_pc[5:0]]);
                store_pending = 1'b0;
            end
            if (dmem_we) begin
                match_store();
            end
            if (!committed && wb_stall == lc4_pipe_pkg::STALL_NONE) begin
                committed = 1'b1;
            end
            if (!committed) begin
                check_bit("o_wb_we", wb_we, 1'b0);
                check_bit("o_dmem_we", dmem_we, 1'b0);
                check_stall("o_wb_stall", wb_stall, lc4_pipe_pkg::STALL_FLUSH);
            end else if (wb_we || wb_stall != lc4_pipe_pkg::STALL_NONE) begin
                match_trace_event();
            end
            if (w_idx == w_kind.size() && st_idx == st_addr.size() && !store_pending) begin
                $display("Test OK");
                $finish;
            end else if (cycles >= cycle_limit) begin
                $display("program did not finish within %0d cycles", cycle_limit);
                stop_failed();
            end
        end
    end

endmodule

`default_nettype wire
